// File: Makefile
VERILATOR ?= verilator
TOP       ?= tbAxiReadInterconnect
FILELIST  ?= filelist.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIMARGS   ?= +verilator+error+limit+100
FAILMSG   ?= Test failed
PASSMSG   ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) $(SIMARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@grep -q "$(PASSMSG)" $(LOG) || (echo "FAIL: no pass line in $(LOG)"; exit 1)
	@echo "PASS"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: dv/axiReadInterconnect_chk.sv
`timescale 1ns/1ps
`default_nettype none

module axiReadInterconnect_chk (
        input logic ACLK,
        input logic ARESETn,
        input logic s0ArValid,
        input logic s0ArReady,
        input logic s1ArValid,
        input logic s1ArReady,
        input logic s2ArValid,
        input logic s2ArReady,
        input logic m0ArValid,
        input logic m0RValid,
        input logic m1RValid,
        input logic coreWait
);

        int assertFails = 0;

        oneSlaveAr: assert property (@(posedge ACLK) disable iff (!ARESETn)
                $onehot0({s0ArValid, s1ArValid, s2ArValid}))
                else begin
                        $error("more than one slave arValid high");
                        assertFails++;
                end

        oneMasterR: assert property (@(posedge ACLK) disable iff (!ARESETn)
                !(m0RValid && m1RValid))
                else begin
                        $error("rValid high toward both masters");
                        assertFails++;
                end

        waitNeedsReq: assert property (@(posedge ACLK) disable iff (!ARESETn)
                coreWait |-> m0ArValid)
                else begin
                        $error("coreWait without an m0 request");
                        assertFails++;
                end

        // ------------------------------
        // AR valid held until ready
        holdS0: assert property (@(posedge ACLK) disable iff (!ARESETn)
                s0ArValid && !s0ArReady |=> s0ArValid)
                else begin
                        $error("s0 arValid dropped before arReady");
                        assertFails++;
                end

        holdS1: assert property (@(posedge ACLK) disable iff (!ARESETn)
                s1ArValid && !s1ArReady |=> s1ArValid)
                else begin
                        $error("s1 arValid dropped before arReady");
                        assertFails++;
                end

        holdS2: assert property (@(posedge ACLK) disable iff (!ARESETn)
                s2ArValid && !s2ArReady |=> s2ArValid)
                else begin
                        $error("s2 arValid dropped before arReady");
                        assertFails++;
                end

endmodule

bind axiReadInterconnect axiReadInterconnect_chk chk (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .s0ArValid (s0ArValid),
        .s0ArReady (s0ArReady),
        .s1ArValid (s1ArValid),
        .s1ArReady (s1ArReady),
        .s2ArValid (s2ArValid),
        .s2ArReady (s2ArReady),
        .m0ArValid (m0ArValid),
        .m0RValid  (m0RValid),
        .m1RValid  (m1RValid),
        .coreWait  (coreWait)
);

`default_nettype wire

// File: dv/tbAxiReadInterconnect.sv
`timescale 1ns/1ps
`default_nettype none

module tbAxiReadInterconnect import axiPkg::*; ();

        localparam int timeoutCycles = 200;
        localparam dataT slaveTag [0:2] = '{32'h0a0a_0000, 32'h0b0b_0000, 32'h0c0c_0000};

        logic ACLK;
        logic ARESETn;
        logic coreWait;

        // master side for m0 and m1
        idT   mArId [2];
        addrT mArAddr [2];
        lenT  mArLen [2];
        logic mArValid [2];
        logic mArReady [2];
        idT   mRId [2];
        dataT mRData [2];
        respT mRResp [2];
        logic mRLast [2];
        logic mRValid [2];
        logic mRReady [2];

        // slave side for s0 to s2
        sidT  sArId [3];
        addrT sArAddr [3];
        lenT  sArLen [3];
        logic sArValid [3];
        logic sArReady [3];
        sidT  sRId [3];
        dataT sRData [3];
        respT sRResp [3];
        logic sRLast [3];
        logic sRValid [3];
        logic sRReady [3];

        int   errors = 0;
        int   seed = 32'h14c8;
        sidT  lastSid [3];                              // sid at each slave's last AR
        time  firstTime [2];
        time  doneTime [2];
        int   coreWaitCycles = 0;
        int   slaveArCycles = 0;

        axiReadInterconnect DUT (
                .ACLK(ACLK), .ARESETn(ARESETn),
                .m0ArId(mArId[0]), .m0ArAddr(mArAddr[0]), .m0ArLen(mArLen[0]),
                .m0ArValid(mArValid[0]), .m0ArReady(mArReady[0]), .m0RId(mRId[0]),
                .m0RData(mRData[0]), .m0RResp(mRResp[0]), .m0RLast(mRLast[0]),
                .m0RValid(mRValid[0]), .m0RReady(mRReady[0]),
                .m1ArId(mArId[1]), .m1ArAddr(mArAddr[1]), .m1ArLen(mArLen[1]),
                .m1ArValid(mArValid[1]), .m1ArReady(mArReady[1]), .m1RId(mRId[1]),
                .m1RData(mRData[1]), .m1RResp(mRResp[1]), .m1RLast(mRLast[1]),
                .m1RValid(mRValid[1]), .m1RReady(mRReady[1]),
                .s0ArId(sArId[0]), .s0ArAddr(sArAddr[0]), .s0ArLen(sArLen[0]),
                .s0ArValid(sArValid[0]), .s0ArReady(sArReady[0]), .s0RId(sRId[0]),
                .s0RData(sRData[0]), .s0RResp(sRResp[0]), .s0RLast(sRLast[0]),
                .s0RValid(sRValid[0]), .s0RReady(sRReady[0]),
                .s1ArId(sArId[1]), .s1ArAddr(sArAddr[1]), .s1ArLen(sArLen[1]),
                .s1ArValid(sArValid[1]), .s1ArReady(sArReady[1]), .s1RId(sRId[1]),
                .s1RData(sRData[1]), .s1RResp(sRResp[1]), .s1RLast(sRLast[1]),
                .s1RValid(sRValid[1]), .s1RReady(sRReady[1]),
                .s2ArId(sArId[2]), .s2ArAddr(sArAddr[2]), .s2ArLen(sArLen[2]),
                .s2ArValid(sArValid[2]), .s2ArReady(sArReady[2]), .s2RId(sRId[2]),
                .s2RData(sRData[2]), .s2RResp(sRResp[2]), .s2RLast(sRLast[2]),
                .s2RValid(sRValid[2]), .s2RReady(sRReady[2]),
                .coreWait(coreWait)
        );

        initial begin
                ACLK = 1'b0;
                forever #10 ACLK = ~ACLK;
        end

        always @(posedge ACLK) begin
                if (coreWait) coreWaitCycles <= coreWaitCycles + 1;
                if (sArValid[0] || sArValid[1] || sArValid[2]) slaveArCycles <= slaveArCycles + 1;
        end

        // ------------------------------
        task automatic checkData(input string name, input dataT exp, input dataT act);
                if (act !== exp) begin
                        $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
                        errors++;
                end
        endtask

        task automatic checkResp(input string name, input respT exp, input respT act);
                if (act !== exp) begin
                        $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
                        errors++;
                end
        endtask

        task automatic checkId(input string name, input idT exp, input idT act);
                if (act !== exp) begin
                        $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
                        errors++;
                end
        endtask

        task automatic checkSid(input string name, input sidT exp, input sidT act);
                if (act !== exp) begin
                        $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
                        errors++;
                end
        endtask

        task automatic checkBit(input string name, input logic exp, input logic act);
                if (act !== exp) begin
                        $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
                        errors++;
                end
        endtask

        // ------------------------------
        // slave model where beat k is (addr + 4k) ^ tag
        task automatic serveSlave(input int idx);
                addrT addr;
                lenT  len;
                sidT  sid;
                int   delay;
                int   k;
                int   cnt;
                sArReady[idx] = 1'b0;
                sRValid[idx]  = 1'b0;
                sRLast[idx]   = 1'b0;
                sRId[idx]     = '0;
                sRData[idx]   = '0;
                sRResp[idx]   = respOkay;
                forever begin
                        @(posedge ACLK);
                        if (ARESETn && sArValid[idx]) begin
                                delay = $unsigned($random(seed)) % 4;
                                repeat (delay) @(posedge ACLK);
                                #1 sArReady[idx] = 1'b1;
                                @(posedge ACLK);                // handshake edge
                                addr = sArAddr[idx];
                                len  = sArLen[idx];
                                sid  = sArId[idx];
                                lastSid[idx] = sid;
                                #1 sArReady[idx] = 1'b0;
                                for (k = 0; k <= int'(len); k++) begin
                                        sRValid[idx] = 1'b1;
                                        sRId[idx]    = sid;
                                        sRData[idx]  = (addr + addrT'(4 * k)) ^ slaveTag[idx];
                                        sRResp[idx]  = respOkay;
                                        sRLast[idx]  = (k == int'(len));
                                        cnt = 0;
                                        do begin
                                                @(posedge ACLK);
                                                cnt++;
                                        end while (!sRReady[idx] && cnt < timeoutCycles);
                                        if (!sRReady[idx]) begin
                                                $display("slave %0d beat %0d was never accepted", idx, k);
                                                errors++;
                                                break;
                                        end
                                        #1;
                                end
                                sRValid[idx] = 1'b0;
                                sRLast[idx]  = 1'b0;
                        end
                end
        endtask

        initial begin
                fork
                        serveSlave(0);
                        serveSlave(1);
                        serveSlave(2);
                join
        end

        // ------------------------------
        // one read burst from master m checked against the address map
        task automatic masterRead(input int m, input idT id, input addrT addr, input lenT len,
                                  input bit randReady);
                int          slv;
                int          k;
                int          cnt;
                logic        fired;
                logic [31:0] rnd;
                dataT        expData;
                respT        expResp;
                slv = int'(addr[widthAddr-1:regionBits]);
                mArId[m]    = id;
                mArAddr[m]  = addr;
                mArLen[m]   = len;
                mArValid[m] = 1'b1;
                cnt = 0;
                do begin
                        @(posedge ACLK);
                        cnt++;
                end while (!mArReady[m] && cnt < timeoutCycles);
                if (!mArReady[m]) begin
                        $display("master %0d read address was never accepted", m);
                        errors++;
                        #1 mArValid[m] = 1'b0;
                        return;
                end
                #1 mArValid[m] = 1'b0;
                for (k = 0; k <= int'(len); k++) begin
                        cnt = 0;
                        do begin
                                rnd = $random(seed);
                                mRReady[m] = randReady ? rnd[0] : 1'b1;
                                @(posedge ACLK);
                                cnt++;
                                fired = mRValid[m] && mRReady[m];
                                if (!fired) #1;
                        end while (!fired && cnt < timeoutCycles);
                        if (!fired) begin
                                $display("master %0d beat %0d never arrived", m, k);
                                errors++;
                                break;
                        end
                        if (k == 0) firstTime[m] = $time;
                        if (k == int'(len)) doneTime[m] = $time;
                        expData = (slv < slaveCount) ? (addr + addrT'(4 * k)) ^ slaveTag[slv] : '0;
                        expResp = (slv < slaveCount) ? respOkay : respDecErr;
                        checkData($sformatf("m%0dRData", m), expData, mRData[m]);
                        checkResp($sformatf("m%0dRResp", m), expResp, mRResp[m]);
                        checkId($sformatf("m%0dRId", m), id, mRId[m]);
                        checkBit($sformatf("m%0dRLast", m), (k == int'(len)), mRLast[m]);
                        #1;
                end
                mRReady[m] = 1'b0;
        endtask

        // ------------------------------
        task automatic burstFromSlave1();
                masterRead(0, 4'h5, 32'h1000_0040, 4'd3, 1'b0);
                checkSid("s1ArId", {1'b0, 4'h5}, lastSid[1]);
        endtask

        task automatic singleFromSlave2();
                masterRead(1, 4'ha, 32'h2000_0100, 4'd0, 1'b0);
                checkSid("s2ArId", {1'b1, 4'ha}, lastSid[2]);
        endtask

        task automatic simultaneousRequests();
                int waitsBefore;
                waitsBefore = coreWaitCycles;
                fork
                        masterRead(0, 4'h3, 32'h0000_0200, 4'd2, 1'b0);
                        masterRead(1, 4'hc, 32'h1000_0300, 4'd1, 1'b0);
                join
                if (doneTime[1] >= firstTime[0]) begin
                        $display("m0 got data before the m1 burst had finished");
                        errors++;
                end
                if (coreWaitCycles == waitsBefore) begin
                        $display("coreWait never rose while m0 was held off");
                        errors++;
                end
                checkBit("coreWait", 1'b0, coreWait);
                checkSid("s0ArId", {1'b0, 4'h3}, lastSid[0]);
                checkSid("s1ArId", {1'b1, 4'hc}, lastSid[1]);
        endtask

        task automatic unmappedRead();
                int arBefore;
                arBefore = slaveArCycles;
                masterRead(0, 4'h7, 32'h3000_0000, 4'd2, 1'b0);
                if (slaveArCycles != arBefore) begin
                        $display("a slave saw arValid for an unmapped address");
                        errors++;
                end
        endtask

        task automatic throttledBurst();
                masterRead(1, 4'h9, 32'h0000_1000, 4'd7, 1'b1);
                checkSid("s0ArId", {1'b1, 4'h9}, lastSid[0]);
        endtask

        // ------------------------------
        initial begin
                int i;
                ARESETn = 1'b0;
                for (i = 0; i < 2; i++) begin
                        mArId[i]    = '0;
                        mArAddr[i]  = '0;
                        mArLen[i]   = '0;
                        mArValid[i] = 1'b0;
                        mRReady[i]  = 1'b0;
                end
                repeat (5) @(posedge ACLK);
                for (i = 0; i < 3; i++) checkBit($sformatf("s%0dArValid", i), 1'b0, sArValid[i]);
                for (i = 0; i < 2; i++) begin
                        checkBit($sformatf("m%0dArReady", i), 1'b0, mArReady[i]);
                        checkBit($sformatf("m%0dRValid", i), 1'b0, mRValid[i]);
                end
                checkBit("coreWait", 1'b0, coreWait);
                #1 ARESETn = 1'b1;
                burstFromSlave1();
                singleFromSlave2();
                simultaneousRequests();
                unmappedRead();
                throttledBurst();
                repeat (2) @(posedge ACLK);
                errors += DUT.chk.assertFails;
                $display("Run finished with %0d errors", errors);
                if (errors == 0) begin
                        $display("Test completed successfully");
                end else begin
                        $display("Test failed");
                end
                $finish;
        end

        initial begin
                #1_000_000;
                $display("Simulation ran too long and was stopped");
                $display("Test failed");
                $finish;
        end

endmodule

`default_nettype wire

// File: filelist.f
verilog/axiPkg.sv
verilog/axiReadIf.sv
verilog/readArbiter.sv
verilog/slaveRouter.sv
verilog/axiReadInterconnect.sv
dv/axiReadInterconnect_chk.sv
dv/tbAxiReadInterconnect.sv

// File: verilog/axiPkg.sv
`default_nettype none

package axiPkg;

        // ------------------------------
        // widths
        localparam int widthId    = 4;
        localparam int widthMid   = 1;                  // master index
        localparam int widthSid   = widthMid + widthId;
        localparam int widthAddr  = 32;
        localparam int widthData  = 32;
        localparam int widthLen   = 4;
        localparam int regionBits = 28;                 // 256MB per slave
        localparam int slaveCount = 3;

        typedef logic [widthId-1:0]   idT;
        typedef logic [widthSid-1:0]  sidT;
        typedef logic [widthAddr-1:0] addrT;
        typedef logic [widthData-1:0] dataT;
        typedef logic [widthLen-1:0]  lenT;
        typedef logic [1:0]           respT;
        typedef logic [1:0]           slaveSelT;

        // ------------------------------
        // address map
        localparam slaveSelT selNone = 2'd3;            // unmapped
        localparam addrT [slaveCount-1:0] slaveBase = {
                32'h2000_0000,
                32'h1000_0000,
                32'h0000_0000
        };

        // response codes
        localparam respT respOkay   = 2'b00;
        localparam respT respDecErr = 2'b11;

endpackage

`default_nettype wire

// File: verilog/axiReadIf.sv
`timescale 1ns/1ps
`default_nettype none

interface axiReadIf import axiPkg::*; #(
        parameter type idType = idT
) ();
        // read address
        idType arId;
        addrT  arAddr;
        lenT   arLen;
        logic  arValid;
        logic  arReady;

        // read data
        idType rId;
        dataT  rData;
        respT  rResp;
        logic  rLast;
        logic  rValid;
        logic  rReady;

        modport mgr (
                output arId, arAddr, arLen, arValid, rReady,
                input  arReady, rId, rData, rResp, rLast, rValid
        );

        modport sub (
                input  arId, arAddr, arLen, arValid, rReady,
                output arReady, rId, rData, rResp, rLast, rValid
        );

endinterface

`default_nettype wire

// File: verilog/axiReadInterconnect.sv
`timescale 1ns/1ps
`default_nettype none

module axiReadInterconnect import axiPkg::*; (
        input  logic ACLK,
        input  logic ARESETn,
        // ------------------------------ m0
        input  idT   m0ArId,
        input  addrT m0ArAddr,
        input  lenT  m0ArLen,
        input  logic m0ArValid,
        output logic m0ArReady,
        output idT   m0RId,
        output dataT m0RData,
        output respT m0RResp,
        output logic m0RLast,
        output logic m0RValid,
        input  logic m0RReady,
        // ------------------------------ m1
        input  idT   m1ArId,
        input  addrT m1ArAddr,
        input  lenT  m1ArLen,
        input  logic m1ArValid,
        output logic m1ArReady,
        output idT   m1RId,
        output dataT m1RData,
        output respT m1RResp,
        output logic m1RLast,
        output logic m1RValid,
        input  logic m1RReady,
        // ------------------------------ s0
        output sidT  s0ArId,
        output addrT s0ArAddr,
        output lenT  s0ArLen,
        output logic s0ArValid,
        input  logic s0ArReady,
        input  sidT  s0RId,
        input  dataT s0RData,
        input  respT s0RResp,
        input  logic s0RLast,
        input  logic s0RValid,
        output logic s0RReady,
        // ------------------------------ s1
        output sidT  s1ArId,
        output addrT s1ArAddr,
        output lenT  s1ArLen,
        output logic s1ArValid,
        input  logic s1ArReady,
        input  sidT  s1RId,
        input  dataT s1RData,
        input  respT s1RResp,
        input  logic s1RLast,
        input  logic s1RValid,
        output logic s1RReady,
        // ------------------------------ s2
        output sidT  s2ArId,
        output addrT s2ArAddr,
        output lenT  s2ArLen,
        output logic s2ArValid,
        input  logic s2ArReady,
        input  sidT  s2RId,
        input  dataT s2RData,
        input  respT s2RResp,
        input  logic s2RLast,
        input  logic s2RValid,
        output logic s2RReady,
        output logic coreWait          // to m0
);

        axiReadIf #(.idType(idT))  m0Bus ();
        axiReadIf #(.idType(idT))  m1Bus ();
        axiReadIf #(.idType(sidT)) sharedBus ();
        axiReadIf #(.idType(sidT)) s0Bus ();
        axiReadIf #(.idType(sidT)) s1Bus ();
        axiReadIf #(.idType(sidT)) s2Bus ();

        // master side
        assign m0Bus.arId    = m0ArId;
        assign m0Bus.arAddr  = m0ArAddr;
        assign m0Bus.arLen   = m0ArLen;
        assign m0Bus.arValid = m0ArValid;
        assign m0Bus.rReady  = m0RReady;
        assign m0ArReady     = m0Bus.arReady;
        assign m0RId         = m0Bus.rId;
        assign m0RData       = m0Bus.rData;
        assign m0RResp       = m0Bus.rResp;
        assign m0RLast       = m0Bus.rLast;
        assign m0RValid      = m0Bus.rValid;

        assign m1Bus.arId    = m1ArId;
        assign m1Bus.arAddr  = m1ArAddr;
        assign m1Bus.arLen   = m1ArLen;
        assign m1Bus.arValid = m1ArValid;
        assign m1Bus.rReady  = m1RReady;
        assign m1ArReady     = m1Bus.arReady;
        assign m1RId         = m1Bus.rId;
        assign m1RData       = m1Bus.rData;
        assign m1RResp       = m1Bus.rResp;
        assign m1RLast       = m1Bus.rLast;
        assign m1RValid      = m1Bus.rValid;

        // slave side
        assign s0ArId        = s0Bus.arId;
        assign s0ArAddr      = s0Bus.arAddr;
        assign s0ArLen       = s0Bus.arLen;
        assign s0ArValid     = s0Bus.arValid;
        assign s0RReady      = s0Bus.rReady;
        assign s0Bus.arReady = s0ArReady;
        assign s0Bus.rId     = s0RId;
        assign s0Bus.rData   = s0RData;
        assign s0Bus.rResp   = s0RResp;
        assign s0Bus.rLast   = s0RLast;
        assign s0Bus.rValid  = s0RValid;

        assign s1ArId        = s1Bus.arId;
        assign s1ArAddr      = s1Bus.arAddr;
        assign s1ArLen       = s1Bus.arLen;
        assign s1ArValid     = s1Bus.arValid;
        assign s1RReady      = s1Bus.rReady;
        assign s1Bus.arReady = s1ArReady;
        assign s1Bus.rId     = s1RId;
        assign s1Bus.rData   = s1RData;
        assign s1Bus.rResp   = s1RResp;
        assign s1Bus.rLast   = s1RLast;
        assign s1Bus.rValid  = s1RValid;

        assign s2ArId        = s2Bus.arId;
        assign s2ArAddr      = s2Bus.arAddr;
        assign s2ArLen       = s2Bus.arLen;
        assign s2ArValid     = s2Bus.arValid;
        assign s2RReady      = s2Bus.rReady;
        assign s2Bus.arReady = s2ArReady;
        assign s2Bus.rId     = s2RId;
        assign s2Bus.rData   = s2RData;
        assign s2Bus.rResp   = s2RResp;
        assign s2Bus.rLast   = s2RLast;
        assign s2Bus.rValid  = s2RValid;

        readArbiter arbiter (
                .ACLK      (ACLK),
                .ARESETn   (ARESETn),
                .m0Bus     (m0Bus.sub),
                .m1Bus     (m1Bus.sub),
                .sharedBus (sharedBus.mgr),
                .coreWait  (coreWait)
        );

        slaveRouter router (
                .ACLK      (ACLK),
                .ARESETn   (ARESETn),
                .sharedBus (sharedBus.sub),
                .s0Bus     (s0Bus.mgr),
                .s1Bus     (s1Bus.mgr),
                .s2Bus     (s2Bus.mgr)
        );

endmodule

`default_nettype wire

// File: verilog/readArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module readArbiter import axiPkg::*; (
        input  logic  ACLK,
        input  logic  ARESETn,
        axiReadIf.sub m0Bus,
        axiReadIf.sub m1Bus,
        axiReadIf.mgr sharedBus,
        output logic  coreWait
);

        typedef enum logic [1:0] {
                grantNone,
                grantM0,
                grantM1
        } grantT;

        grantT               grantQ;
        logic                useM0;
        logic                useM1;
        logic                lastBeat;
        logic [widthMid-1:0] midSel;

        assign useM0    = (grantQ == grantM0);
        assign useM1    = (grantQ == grantM1);
        assign lastBeat = sharedBus.rValid && sharedBus.rReady && sharedBus.rLast;

        // ------------------------------
        // grant held until the last R beat
        always_ff @(posedge ACLK) begin
                if (!ARESETn) begin
                        grantQ <= grantNone;
                end else if (grantQ == grantNone) begin
                        if (m1Bus.arValid) begin
                                grantQ <= grantM1;      // m1 wins a tie
                        end else if (m0Bus.arValid) begin
                                grantQ <= grantM0;
                        end
                end else if (lastBeat) begin
                        grantQ <= grantNone;
                end
        end

        // m0 held off while someone else owns the bus
        assign coreWait = m0Bus.arValid && !useM0;

        // ------------------------------
        // AR toward the router with the index prepended
        assign midSel = useM1 ? widthMid'(1) : widthMid'(0);

        assign sharedBus.arId    = {midSel, (useM1 ? m1Bus.arId : m0Bus.arId)};
        assign sharedBus.arAddr  = useM1 ? m1Bus.arAddr : m0Bus.arAddr;
        assign sharedBus.arLen   = useM1 ? m1Bus.arLen : m0Bus.arLen;
        assign sharedBus.arValid = (useM0 && m0Bus.arValid) || (useM1 && m1Bus.arValid);
        assign sharedBus.rReady  = (useM0 && m0Bus.rReady) || (useM1 && m1Bus.rReady);

        // ------------------------------
        // R back to the owner with the index stripped
        assign m0Bus.arReady = useM0 && sharedBus.arReady;
        assign m0Bus.rId     = sharedBus.rId[widthId-1:0];
        assign m0Bus.rData   = sharedBus.rData;
        assign m0Bus.rResp   = sharedBus.rResp;
        assign m0Bus.rLast   = useM0 && sharedBus.rLast;
        assign m0Bus.rValid  = useM0 && sharedBus.rValid;

        assign m1Bus.arReady = useM1 && sharedBus.arReady;
        assign m1Bus.rId     = sharedBus.rId[widthId-1:0];
        assign m1Bus.rData   = sharedBus.rData;
        assign m1Bus.rResp   = sharedBus.rResp;
        assign m1Bus.rLast   = useM1 && sharedBus.rLast;
        assign m1Bus.rValid  = useM1 && sharedBus.rValid;

endmodule

`default_nettype wire

// File: verilog/slaveRouter.sv
`timescale 1ns/1ps
`default_nettype none

module slaveRouter import axiPkg::*; (
        input  logic  ACLK,
        input  logic  ARESETn,
        axiReadIf.sub sharedBus,
        axiReadIf.mgr s0Bus,
        axiReadIf.mgr s1Bus,
        axiReadIf.mgr s2Bus
);

        slaveSelT sel;
        slaveSelT selQ;
        logic     busyQ;
        logic     arFire;
        logic     rFire;
        logic     errLast;
        lenT      errCntQ;
        lenT      errLenQ;
        sidT      errIdQ;

        // ------------------------------
        // address decode on the region bits
        always_comb begin
                sel = selNone;
                for (int i = 0; i < slaveCount; i++) begin
                        if (sharedBus.arAddr[widthAddr-1:regionBits] ==
                            slaveBase[i][widthAddr-1:regionBits]) begin
                                sel = slaveSelT'(i);
                        end
                end
        end

        // AR only passes while no burst is open
        assign s0Bus.arValid = !busyQ && sharedBus.arValid && (sel == 2'd0);
        assign s1Bus.arValid = !busyQ && sharedBus.arValid && (sel == 2'd1);
        assign s2Bus.arValid = !busyQ && sharedBus.arValid && (sel == 2'd2);

        assign s0Bus.arId   = sharedBus.arId;
        assign s0Bus.arAddr = sharedBus.arAddr;
        assign s0Bus.arLen  = sharedBus.arLen;
        assign s1Bus.arId   = sharedBus.arId;
        assign s1Bus.arAddr = sharedBus.arAddr;
        assign s1Bus.arLen  = sharedBus.arLen;
        assign s2Bus.arId   = sharedBus.arId;
        assign s2Bus.arAddr = sharedBus.arAddr;
        assign s2Bus.arLen  = sharedBus.arLen;

        always_comb begin
                case (sel)
                        2'd0:    sharedBus.arReady = !busyQ && s0Bus.arReady;
                        2'd1:    sharedBus.arReady = !busyQ && s1Bus.arReady;
                        2'd2:    sharedBus.arReady = !busyQ && s2Bus.arReady;
                        default: sharedBus.arReady = !busyQ;  // unmapped address taken at once
                endcase
        end

        assign arFire = sharedBus.arValid && sharedBus.arReady;
        assign rFire  = sharedBus.rValid && sharedBus.rReady;

        // ------------------------------
        // selection held for the burst
        always_ff @(posedge ACLK) begin
                if (!ARESETn) begin
                        busyQ <= 1'b0;
                        selQ  <= selNone;
                end else if (arFire) begin
                        busyQ <= 1'b1;
                        selQ  <= sel;
                end else if (rFire && sharedBus.rLast) begin
                        busyQ <= 1'b0;
                end
        end

        // DECERR beats for unmapped reads
        always_ff @(posedge ACLK) begin
                if (!ARESETn) begin
                        errCntQ <= '0;
                end else if (arFire) begin
                        errCntQ <= '0;
                end else if (rFire && selQ == selNone) begin
                        errCntQ <= errCntQ + lenT'(1);
                end
        end

        always_ff @(posedge ACLK) begin
                if (arFire) begin
                        errLenQ <= sharedBus.arLen;
                        errIdQ  <= sharedBus.arId;
                end
        end

        assign errLast = (errCntQ == errLenQ);

        assign s0Bus.rReady = busyQ && (selQ == 2'd0) && sharedBus.rReady;
        assign s1Bus.rReady = busyQ && (selQ == 2'd1) && sharedBus.rReady;
        assign s2Bus.rReady = busyQ && (selQ == 2'd2) && sharedBus.rReady;

        // ------------------------------
        // R mux
        always_comb begin
                sharedBus.rId    = errIdQ;
                sharedBus.rData  = '0;
                sharedBus.rResp  = respDecErr;
                sharedBus.rLast  = errLast;
                sharedBus.rValid = busyQ && (selQ == selNone);
                case (selQ)
                        2'd0: begin
                                sharedBus.rId    = s0Bus.rId;
                                sharedBus.rData  = s0Bus.rData;
                                sharedBus.rResp  = s0Bus.rResp;
                                sharedBus.rLast  = s0Bus.rLast;
                                sharedBus.rValid = busyQ && s0Bus.rValid;
                        end
                        2'd1: begin
                                sharedBus.rId    = s1Bus.rId;
                                sharedBus.rData  = s1Bus.rData;
                                sharedBus.rResp  = s1Bus.rResp;
                                sharedBus.rLast  = s1Bus.rLast;
                                sharedBus.rValid = busyQ && s1Bus.rValid;
                        end
                        2'd2: begin
                                sharedBus.rId    = s2Bus.rId;
                                sharedBus.rData  = s2Bus.rData;
                                sharedBus.rResp  = s2Bus.rResp;
                                sharedBus.rLast  = s2Bus.rLast;
                                sharedBus.rValid = busyQ && s2Bus.rValid;
                        end
                        default: ;
                endcase
        end

endmodule

`default_nettype wire
